/* design/alu.sv */
`timescale 1ns/1ps

module alu
(
   input  isa_pkg::decoded_t        dec_i,
   input  logic [isa_pkg::XLEN-1:0] a_i,
   input  logic [isa_pkg::XLEN-1:0] b_i,
   input  isa_pkg::flags_t          flags_i,
   output logic [isa_pkg::XLEN-1:0] res_o,
   output isa_pkg::flags_t          flags_o,
   output logic                     wb_ok_o,
   output logic                     flag_ok_o
);
   import isa_pkg::*;

   logic [XLEN-1:0] opb;
   logic [XLEN:0]   sum;    // msb is carry out
   logic [XLEN:0]   diff;   // msb set when no borrow
   logic            add_v;
   logic            sub_v;

   assign opb   = (dec_i.cls == CLS_ALU_I) ? dec_i.imm : b_i;
   assign sum   = {1'b0, a_i} + {1'b0, opb};
   assign diff  = {1'b0, a_i} + {1'b0, ~opb} + 1'b1;
   assign add_v = (a_i[XLEN-1] == opb[XLEN-1]) && (sum[XLEN-1] != a_i[XLEN-1]);
   assign sub_v = (a_i[XLEN-1] != opb[XLEN-1]) && (diff[XLEN-1] != a_i[XLEN-1]);

   always_comb
   begin
      res_o     = '0;
      flags_o   = flags_i;   // c and v kept unless arithmetic
      wb_ok_o   = 1'b1;
      flag_ok_o = 1'b1;
      case (dec_i.alu_op)
         OP_ADD:
         begin
            res_o     = sum[XLEN-1:0];
            flags_o.c = sum[XLEN];
            flags_o.v = add_v;
         end
         OP_SUB, OP_CMP:
         begin
            res_o     = diff[XLEN-1:0];
            flags_o.c = diff[XLEN];
            flags_o.v = sub_v;
            wb_ok_o   = (dec_i.alu_op == OP_SUB);   // cmp drops result
         end
         OP_AND: res_o = a_i & opb;
         OP_OR:  res_o = a_i | opb;
         OP_XOR: res_o = a_i ^ opb;
         OP_SHL: res_o = a_i << opb[4:0];
         OP_SHR: res_o = a_i >> opb[4:0];
         OP_MOV: res_o = opb;
         default:
         begin
            wb_ok_o   = 1'b0;   // undefined op does nothing
            flag_ok_o = 1'b0;
         end
      endcase
      flags_o.s = res_o[XLEN-1];
      flags_o.z = (res_o == '0);
   end

endmodule

/* design/bus_pkg.sv */
package bus_pkg;

   // single shared memory bus, plain strobes
   typedef struct packed {
      logic [31:0] addr;
      logic [31:0] wdata;
      logic        wen;
   } mbus_req_t;

   // one hot instruction phases
   typedef struct packed {
      logic f;   // fetch
      logic e;   // execute, pc increment
      logic m;   // memory access, link, base update
      logic w;   // writeback
   } phase_t;

endpackage

/* design/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core
#(
   parameter logic [isa_pkg::XLEN-1:0] RESET_PC = '0
)
(
   input  logic                     clk,
   input  logic                     rst_n_i,
   output bus_pkg::mbus_req_t       mbus_o,
   input  logic [isa_pkg::XLEN-1:0] mbus_rdata_i,
   input  logic [3:0]               test_rsel_i,
   output logic [isa_pkg::XLEN-1:0] test_reg_o,
   output bus_pkg::phase_t          phase_o
);
   import isa_pkg::*;

   logic [XLEN-1:0] ic_q;        // instruction register
   flags_t          flags_q;
   logic [XLEN-1:0] ld_data_q;
   logic [XLEN-1:0] pc;
   logic [XLEN-1:0] da;
   logic [XLEN-1:0] db;
   logic [XLEN-1:0] dd;
   decoded_t        dec;
   logic [XLEN-1:0] ldst_addr;
   logic [XLEN-1:0] base_new;
   logic [XLEN-1:0] alu_res;
   flags_t          alu_flags;
   logic            alu_wb_ok;
   logic            alu_flag_ok;
   logic            is_alu;
   logic            rd_write;
   logic            pc_load;
   logic [XLEN-1:0] wb_data;

   phase_sched u_sched (.clk(clk), .rst_n_i(rst_n_i), .phase_o(phase_o));

   pc_counter #(.RESET_PC(RESET_PC)) u_pc
   (
      .clk(clk), .rst_n_i(rst_n_i),
      .inc_i(phase_o.e),
      .load_i(pc_load),
      .load_val_i(wb_data),
      .pc_o(pc)
   );

   reg_file u_regs
   (
      .clk(clk), .rst_n_i(rst_n_i),
      .ra_i(dec.ra), .rb_i(dec.rb), .rd_i(dec.rd),
      .test_rsel_i(test_rsel_i), .pc_i(pc),
      .wb_en_i(phase_o.w && dec.ena && rd_write && !dec.writes_pc),
      .wb_addr_i(dec.rd), .wb_data_i(wb_data),
      .base_en_i(phase_o.m && dec.ena &&
                 (((dec.is_ld || dec.is_st) && dec.s_w) || dec.is_call)),
      .base_data_i(dec.is_call ? pc : base_new),   // link gets the next pc
      .da_o(da), .db_o(db), .dd_o(dd), .test_reg_o(test_reg_o)
   );

   insn_decode u_dec
   (
      .ic_i(ic_q), .flags_i(flags_q), .da_i(da), .db_i(db),
      .dec_o(dec), .ldst_addr_o(ldst_addr), .base_new_o(base_new)
   );

   alu u_alu
   (
      .dec_i(dec), .a_i(da), .b_i(db), .flags_i(flags_q),
      .res_o(alu_res), .flags_o(alu_flags),
      .wb_ok_o(alu_wb_ok), .flag_ok_o(alu_flag_ok)
   );

   assign is_alu   = (dec.cls == CLS_ALU_R) || (dec.cls == CLS_ALU_I);
   assign rd_write = (is_alu && alu_wb_ok) || dec.is_ld;
   assign pc_load  = phase_o.w && dec.ena && dec.writes_pc && (dec.is_call || rd_write);
   assign wb_data  = dec.is_call ? {{(XLEN-IM24_W){1'b0}}, dec.im24} :
                     dec.is_ld   ? ld_data_q : alu_res;

   always_ff @(posedge clk)
   begin
      if (phase_o.f)
         ic_q <= mbus_rdata_i;
      if (phase_o.m && dec.ena && dec.is_ld)
         ld_data_q <= mbus_rdata_i;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
         flags_q <= '0;
      else if (phase_o.w && dec.ena && is_alu && dec.s_w && alu_flag_ok)
         flags_q <= alu_flags;
   end

   // bus address is the pc except for a live ld/st in memory phase
   always_comb
   begin
      mbus_o.addr = pc;
      if (phase_o.m && dec.ena && (dec.is_ld || dec.is_st))
         mbus_o.addr = ldst_addr;
      mbus_o.wdata = dd;   // store data from rd
      mbus_o.wen   = phase_o.m && dec.ena && dec.is_st;
   end

endmodule

/* design/insn_decode.sv */
`timescale 1ns/1ps

module insn_decode
(
   input  logic [isa_pkg::XLEN-1:0] ic_i,
   input  isa_pkg::flags_t          flags_i,
   input  logic [isa_pkg::XLEN-1:0] da_i,
   input  logic [isa_pkg::XLEN-1:0] db_i,
   output isa_pkg::decoded_t        dec_o,
   output logic [isa_pkg::XLEN-1:0] ldst_addr_o,
   output logic [isa_pkg::XLEN-1:0] base_new_o
);
   import isa_pkg::*;

   insn_class_e     cls;
   cond_e           cond;
   logic            cond_ok;
   logic            is_alu;
   logic            is_ld;
   logic            is_st;
   logic [3:0]      rd;
   logic [XLEN-1:0] imm;
   logic [XLEN-1:0] offset;
   logic [XLEN-1:0] addr_sum;

   assign cls    = insn_class_e'(ic_i[IC_CLS_LSB +: 3]);
   assign cond   = cond_e'(ic_i[IC_COND_LSB +: 4]);
   assign rd     = ic_i[IC_RD_LSB +: 4];
   assign imm    = {{(XLEN-IMM_W){ic_i[IMM_W-1]}}, ic_i[IMM_W-1:0]};
   assign is_alu = (cls == CLS_ALU_R) || (cls == CLS_ALU_I);
   assign is_ld  = (cls == CLS_LD_R) || (cls == CLS_LD_I);
   assign is_st  = (cls == CLS_ST_R) || (cls == CLS_ST_I);

   always_comb
   begin
      cond_ok = 1'b1;
      case (cond)
         COND_AL, COND_UN: cond_ok = 1'b1;
         COND_EQ: cond_ok = flags_i.z;
         COND_NE: cond_ok = !flags_i.z;
         COND_CS: cond_ok = flags_i.c;
         COND_CC: cond_ok = !flags_i.c;
         COND_MI: cond_ok = flags_i.s;
         COND_PL: cond_ok = !flags_i.s;
         COND_VS: cond_ok = flags_i.v;
         COND_VC: cond_ok = !flags_i.v;
         COND_HI: cond_ok = flags_i.c && !flags_i.z;   // unsigned a > b
         COND_LS: cond_ok = !flags_i.c || flags_i.z;
         COND_GE: cond_ok = !(flags_i.s ^ flags_i.v);  // signed
         COND_LT: cond_ok = flags_i.s ^ flags_i.v;
         COND_GT: cond_ok = !flags_i.z && !(flags_i.s ^ flags_i.v);
         COND_LE: cond_ok = flags_i.z || (flags_i.s ^ flags_i.v);
      endcase
   end

   // register offset for the _r forms, imm12 for the _i forms
   assign offset      = ((cls == CLS_ST_I) || (cls == CLS_LD_I)) ? imm : db_i;
   assign addr_sum    = da_i + offset;
   assign ldst_addr_o = addr_sum;
   assign base_new_o  = addr_sum;

   always_comb
   begin
      dec_o.ena       = cond_ok;
      dec_o.cls       = cls;
      dec_o.s_w       = ic_i[IC_SW_BIT];
      dec_o.rd        = rd;
      // a call links through the base port, so ra points at r14
      dec_o.ra        = (cls == CLS_CALL) ? LINK_REG : ic_i[IC_RA_LSB +: 4];
      dec_o.rb        = ic_i[IC_RB_LSB +: 4];
      dec_o.alu_op    = alu_op_e'(ic_i[IC_OP_LSB +: 4]);
      dec_o.imm       = imm;
      dec_o.im24      = ic_i[IM24_W-1:0];
      dec_o.is_ld     = is_ld;
      dec_o.is_st     = is_st;
      dec_o.is_call   = (cls == CLS_CALL);
      dec_o.writes_pc = (cls == CLS_CALL) || ((is_alu || is_ld) && rd == PC_REG);
   end

endmodule

/* design/isa_pkg.sv */
package isa_pkg;

   localparam int XLEN = 32;

   // instruction field positions
   localparam int IC_COND_LSB = 28;
   localparam int IC_CLS_LSB  = 25;
   localparam int IC_SW_BIT   = 24;   // S for alu, W for ld/st
   localparam int IC_RD_LSB   = 20;
   localparam int IC_RA_LSB   = 16;
   localparam int IC_OP_LSB   = 12;
   localparam int IC_RB_LSB   = 8;
   localparam int IMM_W       = 12;
   localparam int IM24_W      = 24;

   localparam logic [3:0] LINK_REG = 4'd14;
   localparam logic [3:0] PC_REG   = 4'd15;

   typedef enum logic [2:0] {
      CLS_ALU_R = 3'd0,
      CLS_ALU_I = 3'd1,
      CLS_CALL  = 3'd2,
      CLS_NOP   = 3'd3,   // decodes to nothing
      CLS_ST_R  = 3'd4,
      CLS_LD_R  = 3'd5,
      CLS_ST_I  = 3'd6,
      CLS_LD_I  = 3'd7
   } insn_class_e;

   typedef enum logic [3:0] {
      OP_ADD = 4'd0,
      OP_SUB = 4'd1,
      OP_AND = 4'd2,
      OP_OR  = 4'd3,
      OP_XOR = 4'd4,
      OP_SHL = 4'd5,
      OP_SHR = 4'd6,
      OP_MOV = 4'd7,
      OP_CMP = 4'd8     // flags only
   } alu_op_e;

   typedef enum logic [3:0] {
      COND_AL = 4'h0, COND_EQ = 4'h1, COND_NE = 4'h2, COND_CS = 4'h3,
      COND_CC = 4'h4, COND_MI = 4'h5, COND_PL = 4'h6, COND_VS = 4'h7,
      COND_VC = 4'h8, COND_HI = 4'h9, COND_LS = 4'ha, COND_GE = 4'hb,
      COND_LT = 4'hc, COND_GT = 4'hd, COND_LE = 4'he, COND_UN = 4'hf
   } cond_e;

   typedef struct packed {
      logic c;
      logic s;
      logic z;
      logic v;
   } flags_t;

   typedef struct packed {
      logic              ena;        // condition true
      insn_class_e       cls;
      logic              s_w;        // bit 24
      logic [3:0]        rd;
      logic [3:0]        ra;
      logic [3:0]        rb;
      alu_op_e           alu_op;
      logic [XLEN-1:0]   imm;        // sign extended imm12
      logic [IM24_W-1:0] im24;
      logic              is_ld;
      logic              is_st;
      logic              is_call;
      logic              writes_pc;
   } decoded_t;

endpackage

/* design/pc_counter.sv */
`timescale 1ns/1ps

module pc_counter
#(
   parameter logic [isa_pkg::XLEN-1:0] RESET_PC = '0
)
(
   input  logic                     clk,
   input  logic                     rst_n_i,
   input  logic                     inc_i,
   input  logic                     load_i,
   input  logic [isa_pkg::XLEN-1:0] load_val_i,
   output logic [isa_pkg::XLEN-1:0] pc_o
);

   // word addressed, one step per instruction
   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         pc_o <= RESET_PC;
      end
      else if (load_i)
      begin
         pc_o <= load_val_i;   // jump wins over increment
      end
      else if (inc_i)
      begin
         pc_o <= pc_o + 1'b1;
      end
   end

endmodule

/* design/phase_sched.sv */
`timescale 1ns/1ps

module phase_sched
(
   input  logic            clk,
   input  logic            rst_n_i,
   output bus_pkg::phase_t phase_o
);
   import bus_pkg::*;

   phase_t nxt;

   always_comb
   begin
      nxt = '0;
      if (phase_o.f)
         nxt.e = 1'b1;
      else if (phase_o.e)
         nxt.m = 1'b1;
      else if (phase_o.m)
         nxt.w = 1'b1;
      else
         nxt.f = 1'b1;   // after writeback, also recovers a bad state
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         phase_o   <= '0;
         phase_o.f <= 1'b1;
      end
      else
      begin
         phase_o <= nxt;
      end
   end

endmodule

/* design/reg_file.sv */
`timescale 1ns/1ps

module reg_file
(
   input  logic                     clk,
   input  logic                     rst_n_i,
   input  logic [3:0]               ra_i,
   input  logic [3:0]               rb_i,
   input  logic [3:0]               rd_i,
   input  logic [3:0]               test_rsel_i,
   input  logic [isa_pkg::XLEN-1:0] pc_i,
   input  logic                     wb_en_i,
   input  logic [3:0]               wb_addr_i,
   input  logic [isa_pkg::XLEN-1:0] wb_data_i,
   input  logic                     base_en_i,
   input  logic [isa_pkg::XLEN-1:0] base_data_i,
   output logic [isa_pkg::XLEN-1:0] da_o,
   output logic [isa_pkg::XLEN-1:0] db_o,
   output logic [isa_pkg::XLEN-1:0] dd_o,
   output logic [isa_pkg::XLEN-1:0] test_reg_o
);
   import isa_pkg::*;

   logic [XLEN-1:0] regs [0:14];   // r15 lives in pc_counter

   // wb port is used in writeback, base port in memory phase
   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         for (int i = 0; i < 15; i++)
            regs[i] <= '0;
      end
      else
      begin
         if (wb_en_i && wb_addr_i != PC_REG)
            regs[wb_addr_i] <= wb_data_i;
         if (base_en_i && ra_i != PC_REG)
            regs[ra_i] <= base_data_i;   // base update or link
      end
   end

   // index 15 reads the pc
   assign da_o       = (ra_i == PC_REG)        ? pc_i : regs[ra_i];
   assign db_o       = (rb_i == PC_REG)        ? pc_i : regs[rb_i];
   assign dd_o       = (rd_i == PC_REG)        ? pc_i : regs[rd_i];
   assign test_reg_o = (test_rsel_i == PC_REG) ? pc_i : regs[test_rsel_i];

endmodule

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and decide on the pass message in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_cpu -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" &&
echo "run_sim: simulation passed" ||
{ echo "run_sim: simulation failed"; exit 1; }

/* sim/cpu_assert.sv */
`timescale 1ns/1ps

module cpu_assert
#(
   parameter logic [31:0] RESET_PC = '0
)
(
   input logic               clk,
   input logic               rst_n_i,
   input bus_pkg::phase_t    phase_i,
   input bus_pkg::mbus_req_t mbus_i
);

   a_onehot: assert property (@(posedge clk) disable iff (!rst_n_i) $onehot(phase_i))
      else $error("phase not one-hot");
   a_wen_mem: assert property (@(posedge clk) disable iff (!rst_n_i) mbus_i.wen |-> phase_i.m)
      else $error("store strobe outside memory phase");
   a_reset_fetch: assert property (@(posedge clk)
         $rose(rst_n_i) |-> (phase_i.f && mbus_i.addr == RESET_PC))
      else $error("first cycle after reset is not a fetch at the reset pc");

   // f, e, m, w in turn
   a_order: assert property (@(posedge clk) disable iff (!rst_n_i)
         $past(rst_n_i) |-> phase_i == {$past(phase_i.w), $past(phase_i.f),
                                        $past(phase_i.e), $past(phase_i.m)})
      else $error("phase order broken");

endmodule

bind cpu_core cpu_assert #(.RESET_PC(RESET_PC)) u_assert
(
   .clk(clk), .rst_n_i(rst_n_i), .phase_i(phase_o), .mbus_i(mbus_o)
);

/* sim/cpu_checker.sv */
`timescale 1ns/1ps

module cpu_checker
(
   input logic               clk,
   input logic               rst_n_i,
   input bus_pkg::mbus_req_t mbus_i,
   input bus_pkg::phase_t    phase_i,
   input logic               check_en_i,
   input logic [3:0]         test_rsel_i,
   input logic [31:0]        test_reg_i
);
   import bus_pkg::*;

   logic [31:0] exp_addr [0:15];
   logic [31:0] exp_data [0:15];
   logic [31:0] exp_reg  [0:14];
   int          n_exp = 0;
   int          n_seen = 0;
   int          errors = 0;
   logic [1:0]  ph_step;   // cycles since reset, mod 4
   phase_t      ph_exp;

   task automatic clear_expect();
      n_exp  = 0;
      n_seen = 0;
   endtask

   task automatic add_store(input logic [31:0] a, input logic [31:0] d);
      exp_addr[n_exp] = a;
      exp_data[n_exp] = d;
      n_exp++;
   endtask

   task automatic set_reg(input int r, input logic [31:0] v);
      exp_reg[r] = v;
   endtask

   task automatic finish_test();
      if (n_seen != n_exp)
      begin
         $display("store count wrong, %0d stores seen but %0d expected", n_seen, n_exp);
         errors++;
      end
   endtask

   // stores in program order
   always @(posedge clk)
   begin
      if (rst_n_i && mbus_i.wen)
      begin
         if (n_seen >= n_exp)
         begin
            $display("extra store of %h to address %h", mbus_i.wdata, mbus_i.addr);
            errors++;
         end
         else if (mbus_i.addr !== exp_addr[n_seen] || mbus_i.wdata !== exp_data[n_seen])
         begin
            $display("** Error at %0t: store %0d expected [%h] <= %h, got [%h] <= %h",
                     $time, n_seen, exp_addr[n_seen], exp_data[n_seen],
                     mbus_i.addr, mbus_i.wdata);
            errors++;
         end
         n_seen++;
      end
   end

   always @(posedge clk)
   begin
      if (check_en_i && test_reg_i !== exp_reg[test_rsel_i])
      begin
         $display("** Error at %0t: r%0d expected %h, got %h",
                  $time, test_rsel_i, exp_reg[test_rsel_i], test_reg_i);
         errors++;
      end
   end

   // fetch first after reset, then one phase per cycle
   assign ph_exp = phase_t'(4'b1000 >> ph_step);

   always @(posedge clk)
   begin
      if (!rst_n_i)
         ph_step <= 2'd0;
      else
      begin
         if (phase_i !== ph_exp)
         begin
            $display("** Error at %0t: phase expected %b, got %b", $time, ph_exp, phase_i);
            errors++;
         end
         ph_step <= ph_step + 2'd1;
      end
   end

endmodule

/* sim/cpu_golden.txt */
// number of tests, then per test: id, program length, program words,
// store count with (address data) pairs, expected r0..r14
4
1 0d
02107005 02210003 00321101 0242200C 00513201 0262400F 02715004 02876002 00907200 02A18005 0C100080 0C0000FF 02F0700C
2 00000080 00000005 000000FF 00000000
0 5 8 3 8 D 7 50 14 8 0 0 0 0 0
2 0e
02107005 03018005 12207001 22307001 32407001 03018007 C2507001 D2607001 E2707001 03811005 22907001 12A10002 0C0000FF 02F0700D
1 000000FF 00000000
0 5 1 0 1 1 0 1 0 0 7 0 0 0 0
3 09
02107040 02207234 02307004 08210300 0D310008 0E410FFC 0B560100 0C0000FF 02F07008
3 00000044 00000234 00000048 00000004 000000FF 00000000
0 48 234 4 234 4 48 0 0 0 0 0 0 0 0
4 0c
02107001 04000005 02207009 02307009 02407009 02507002 02F00009 02607009 02707009 02807003 0C0000FF 02F0700B
1 000000FF 00000000
0 1 0 0 0 2 0 0 3 0 0 0 0 0 2

/* sim/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu;
   import bus_pkg::*;

   logic        clk;
   logic        rst_n_i;
   mbus_req_t   mbus;
   logic [31:0] rdata;
   logic [3:0]  test_rsel;
   logic [31:0] test_reg;
   phase_t      phase;
   logic        chk_en;

   logic [31:0] gold  [0:1023];   // flat word stream from the golden file
   logic [31:0] mem   [0:255];
   logic [31:0] image [0:255];    // program image copied in during reset
   int          ptr;
   int          test_id;
   int          n_pass;
   int          n_fail;

   cpu_core #(.RESET_PC(32'd0)) DUT
   (
      .clk(clk), .rst_n_i(rst_n_i),
      .mbus_o(mbus), .mbus_rdata_i(rdata),
      .test_rsel_i(test_rsel), .test_reg_o(test_reg),
      .phase_o(phase)
   );

   cpu_checker u_chk
   (
      .clk(clk), .rst_n_i(rst_n_i), .mbus_i(mbus), .phase_i(phase),
      .check_en_i(chk_en), .test_rsel_i(test_rsel), .test_reg_i(test_reg)
   );

   // combinational read, write at the clock edge
   always @(posedge clk)
   begin
      if (!rst_n_i)
         mem <= image;
      else if (mbus.wen)
         mem[mbus.addr[7:0]] <= mbus.wdata;
   end

   assign rdata = mem[mbus.addr[7:0]];

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] next_word();
      logic [31:0] w;
      w   = gold[ptr];
      ptr = ptr + 1;
      return w;
   endfunction

   task automatic load_test();
      int          n;
      logic [31:0] a;
      logic [31:0] d;
      test_id = next_word();
      n       = next_word();
      for (int i = 0; i < 256; i++)
         image[i] = '0;
      for (int i = 0; i < n; i++)
         image[i] = next_word();
      n = next_word();
      u_chk.clear_expect();
      for (int i = 0; i < n; i++)
      begin
         a = next_word();
         d = next_word();
         u_chk.add_store(a, d);
      end
      for (int r = 0; r < 15; r++)
         u_chk.set_reg(r, next_word());
   endtask

   task automatic run_test();
      int   errs_before;
      logic done;
      errs_before = u_chk.errors;
      @(negedge clk);
      rst_n_i = 1'b0;
      repeat (8) @(negedge clk);
      rst_n_i = 1'b1;
      done = 1'b0;
      for (int cyc = 0; cyc < 2000 && !done; cyc++)
      begin
         @(negedge clk);
         if (mbus.wen && mbus.addr == 32'd255)
            done = 1'b1;   // end marker store
      end
      if (!done)
      begin
         $display("test %0d: no store to address 255 within 2000 cycles, timed out", test_id);
         n_fail++;
      end
      else
      begin
         @(negedge clk);
         chk_en = 1'b1;
         for (int r = 0; r < 15; r++)
         begin
            test_rsel = r[3:0];
            @(negedge clk);
         end
         chk_en = 1'b0;
         u_chk.finish_test();
         if (u_chk.errors == errs_before)
         begin
            $display("test %0d: passed", test_id);
            n_pass++;
         end
         else
         begin
            $display("test %0d: failed", test_id);
            n_fail++;
         end
      end
   endtask

   initial
   begin
      int n_tests;
      rst_n_i   = 1'b0;
      test_rsel = '0;
      chk_en    = 1'b0;
      n_pass    = 0;
      n_fail    = 0;
      ptr       = 0;
      for (int i = 0; i < 256; i++)
         image[i] = '0;
      $readmemh("sim/cpu_golden.txt", gold);
      n_tests = next_word();
      for (int t = 0; t < n_tests; t++)
      begin
         load_test();
         run_test();
      end
      $display("%0d tests, %0d passed, %0d failed, %0d check errors",
               n_tests, n_pass, n_fail, u_chk.errors);
      if (n_fail == 0 && u_chk.errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

/* verilog.f */
design/isa_pkg.sv
design/bus_pkg.sv
design/phase_sched.sv
design/pc_counter.sv
design/reg_file.sv
design/alu.sv
design/insn_decode.sv
design/cpu_core.sv
sim/cpu_checker.sv
sim/cpu_assert.sv
sim/tb_cpu.sv
